//--- build.f
logic/cpu_defs_pkg.sv
logic/wb_bus_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/pipeline_control.sv
logic/mycpu_top.sv
testbench/mycpu_sva.sv
testbench/tb_mycpu.sv

//--- testbench/tb_mycpu.sv
// mycpu core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mycpu;

    localparam logic [31:0] reset_pc   = 32'h0000_0000;
    localparam logic [31:0] halt_pc    = 32'h0000_0078;    // j to itself
    localparam int          max_cycles = 4000;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } retire_t;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] data;
    } store_t;

    logic                aclk;
    logic                rst;
    wb_bus_pkg::wb_req_t ibus_req, dbus_req;
    wb_bus_pkg::wb_rsp_t ibus_rsp, dbus_rsp;
    logic [31:0]         debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]          debug_wb_rf_wen;
    logic [4:0]          debug_wb_rf_wnum;

    logic [31:0] imem [32];
    logic [31:0] dmem [64];
    retire_t     exp_retire [$];
    store_t      exp_store [$];
    logic [31:0] rng = 32'hb2d6_161c;
    int          i_wait, d_wait, halt_fetches, errors;
    logic        i_started, d_started, first_fetch;

    mycpu_top #(.reset_pc(reset_pc)) uut (
        .aclk              (aclk),
        .rst               (rst),
        .ibus_req          (ibus_req),
        .ibus_rsp          (ibus_rsp),
        .dbus_req          (dbus_req),
        .dbus_rsp          (dbus_rsp),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    bind mycpu_top mycpu_sva u_sva (
        .aclk             (aclk),
        .rst              (rst),
        .ibus_req         (ibus_req),
        .ibus_rsp         (ibus_rsp),
        .dbus_req         (dbus_req),
        .dbus_rsp         (dbus_rsp),
        .debug_wb_rf_wen  (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum)
    );

    always #4 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'hc0de_0000 ^ idx;
    endfunction

    function automatic logic [31:0] r_op(input logic [5:0] fn, input int rd, rs, rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_op(input logic [5:0] op, input int rt, rs,
                                         input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] j_op(input logic [31:0] target);
        return {op_j, target[27:2]};
    endfunction

    // nop outside the program
    function automatic logic [31:0] imem_word(input logic [31:0] adr);
        return (adr[31:7] == '0) ? imem[adr[6:2]] : 32'h0;
    endfunction

    task automatic load_program();
        for (int k = 0; k < 32; k++)
            imem[k] = 32'h0;
        imem[0]  = i_op(op_lui,    1,  0, 16'h1234);
        imem[1]  = i_op(op_ori,    1,  1, 16'h5678);   // uses r1 right away
        imem[2]  = i_op(op_addiu,  2,  0, 16'hfff8);
        imem[3]  = r_op(fn_addu,   3,  1, 2);
        imem[4]  = r_op(fn_subu,   4,  3, 1);
        imem[5]  = r_op(fn_and,    5,  1, 4);
        imem[6]  = r_op(fn_or,     6,  2, 3);
        imem[7]  = r_op(fn_xor,    7,  6, 1);
        imem[8]  = r_op(fn_slt,    8,  2, 1);
        imem[9]  = r_op(fn_slt,    9,  1, 2);
        imem[10] = i_op(op_addiu,  0,  1, 16'h0005);   // r0 stays zero
        imem[11] = r_op(fn_addu,  10,  0, 1);
        imem[12] = i_op(op_sw,     7,  0, 16'h0008);
        imem[13] = i_op(op_lw,    11,  0, 16'h0008);
        imem[14] = r_op(fn_addu,  12, 11, 1);          // load used at once
        imem[15] = i_op(op_lw,    13,  0, 16'h0010);
        imem[16] = i_op(op_sw,    13,  0, 16'h0014);
        imem[17] = i_op(op_beq,    9,  8, 16'h0002);   // not taken
        imem[18] = i_op(op_bne,    9,  8, 16'h0002);   // taken to 0x54
        imem[19] = i_op(op_addiu, 14,  0, 16'h0111);
        imem[20] = i_op(op_addiu, 15,  0, 16'h0222);
        imem[21] = i_op(op_beq,    1, 10, 16'h0001);   // taken to 0x5c
        imem[22] = i_op(op_addiu, 16,  0, 16'h0333);
        imem[23] = j_op(32'h0000_0068);
        imem[24] = i_op(op_addiu, 17,  0, 16'h0444);
        imem[25] = i_op(op_addiu, 18,  0, 16'h0555);
        imem[26] = i_op(op_addiu, 19, 12, 16'h0001);
        imem[27] = i_op(op_addiu, 20,  0, 16'h0040);
        imem[28] = i_op(op_sw,    19, 20, 16'h0004);
        imem[29] = i_op(op_lw,    21, 20, 16'h0004);
        imem[30] = j_op(halt_pc);
        imem[31] = i_op(op_addiu, 22,  0, 16'h0666);   // never retires
    endtask

    // isa model without delay slots that stops at the halt loop
    task automatic run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] pc, npc, ins, a, b, simm, eff, res;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        for (int k = 0; k < 32; k++)
            regs[k] = 32'h0;
        for (int k = 0; k < 64; k++)
            mem[k] = fill_word(k);
        pc    = reset_pc;
        steps = 0;
        while (imem_word(pc) != j_op(pc) && steps < 1000) begin
            ins  = imem_word(pc);
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            eff  = a + simm;
            dst  = ins[20:16];
            wr   = 1'b1;
            res  = 32'h0;
            npc  = pc + 32'd4;
            case (ins[31:26])
                op_special: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                op_addiu: res = eff;
                op_ori:   res = a | {16'h0000, ins[15:0]};
                op_lui:   res = {ins[15:0], 16'h0000};
                op_lw:    res = mem[eff[7:2]];
                op_sw: begin
                    wr = 1'b0;
                    mem[eff[7:2]] = b;
                    exp_store.push_back(store_t'{eff, b});
                end
                op_beq: begin
                    wr = 1'b0;
                    if (a == b)
                        npc = npc + (simm << 2);
                end
                op_bne: begin
                    wr = 1'b0;
                    if (a != b)
                        npc = npc + (simm << 2);
                end
                op_j: begin
                    wr  = 1'b0;
                    npc = {npc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_retire.push_back(retire_t'{pc, dst, res});
            end
            pc = npc;
            steps++;
        end
        assert (steps < 1000) else begin
            $display("reference model never reached the halt loop");
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire();
        retire_t e;
        check_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'hf);
        assert (exp_retire.size() > 0) else begin
            $display("unexpected retirement of pc 0x%h after the last expected one", debug_wb_pc);
            errors++;
        end
        if (exp_retire.size() > 0) begin
            e = exp_retire.pop_front();
            check_value("debug_wb_pc", debug_wb_pc, e.pc);
            check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum}, {27'd0, e.num});
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, e.data);
        end
    endtask

    task automatic serve_ibus();
        if (ibus_rsp.ack) begin
            ibus_rsp.ack = 1'b0;    // one ack per request
            i_started    = 1'b0;
        end else if (ibus_req.cyc && ibus_req.stb) begin
            if (!i_started) begin
                i_started = 1'b1;
                rng       = xorshift32(rng);
                i_wait    = rng[1:0];
                if (!first_fetch) begin
                    first_fetch = 1'b1;
                    check_value("ibus_req.adr", ibus_req.adr, reset_pc);
                end
            end
            if (i_wait == 0) begin
                ibus_rsp.ack   = 1'b1;
                ibus_rsp.dat_r = imem_word(ibus_req.adr);
                check_value("ibus_req.we", {31'd0, ibus_req.we}, 32'h0);
                check_value("ibus_req.sel", {28'd0, ibus_req.sel}, 32'hf);
                if (ibus_req.adr == halt_pc)
                    halt_fetches++;
            end else
                i_wait--;
        end
    endtask

    task automatic serve_dbus();
        store_t st;
        if (dbus_rsp.ack) begin
            dbus_rsp.ack = 1'b0;
            d_started    = 1'b0;
        end else if (dbus_req.cyc && dbus_req.stb) begin
            if (!d_started) begin
                d_started = 1'b1;
                rng       = xorshift32(rng);
                d_wait    = rng[1:0];
            end
            if (d_wait == 0) begin
                dbus_rsp.ack = 1'b1;
                check_value("dbus_req.sel", {28'd0, dbus_req.sel}, 32'hf);
                if (dbus_req.we) begin
                    assert (exp_store.size() > 0) else begin
                        $display("data bus write to 0x%h that the program never makes",
                                 dbus_req.adr);
                        errors++;
                    end
                    if (exp_store.size() > 0) begin
                        st = exp_store.pop_front();
                        check_value("dbus_req.adr", dbus_req.adr, st.adr);
                        check_value("dbus_req.dat_w", dbus_req.dat_w, st.data);
                    end
                    dmem[dbus_req.adr[7:2]] = dbus_req.dat_w;
                end else
                    dbus_rsp.dat_r = dmem[dbus_req.adr[7:2]];
            end else
                d_wait--;
        end
    endtask

    // slaves and trace checker all act on the falling edge
    always @(negedge aclk) begin
        serve_ibus();
        serve_dbus();
        if (!rst && debug_wb_rf_wen != 4'h0)
            check_retire();
    end

    initial begin
        int cycles;
        aclk         = 1'b0;
        rst          = 1'b1;
        ibus_rsp     = '0;
        dbus_rsp     = '0;
        i_started    = 1'b0;
        d_started    = 1'b0;
        first_fetch  = 1'b0;
        i_wait       = 0;
        d_wait       = 0;
        halt_fetches = 0;
        errors       = 0;
        load_program();
        for (int k = 0; k < 64; k++)
            dmem[k] = fill_word(k);
        run_reference();
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst    = 1'b0;
        cycles = 0;
        // done once the halt loop spins and nothing is left to retire or store
        while (!(halt_fetches >= 3 && exp_retire.size() == 0 && exp_store.size() == 0)
               && cycles < max_cycles) begin
            @(posedge aclk);
            cycles++;
        end
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles with %0d retirements and %0d stores pending",
                     cycles, exp_retire.size(), exp_store.size());
            errors++;
        end
        $display("check errors: %0d, assertion errors: %0d", errors, uut.u_sva.fails);
        if (errors == 0 && uut.u_sva.fails == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/mycpu_sva.sv
// bus protocol and trace checks
`timescale 1ns/1ps
`default_nettype none

module mycpu_sva (
    input logic                aclk,
    input logic                rst,
    input wb_bus_pkg::wb_req_t ibus_req,
    input wb_bus_pkg::wb_rsp_t ibus_rsp,
    input wb_bus_pkg::wb_req_t dbus_req,
    input wb_bus_pkg::wb_rsp_t dbus_rsp,
    input logic [3:0]          debug_wb_rf_wen,
    input logic [4:0]          debug_wb_rf_wnum
);
    int unsigned fails = 0;    // read by the testbench

    a_ibus_cyc_stb: assert property (@(posedge aclk) disable iff (rst)
        ibus_req.cyc == ibus_req.stb)
        else begin $error("ibus cyc and stb differ"); fails++; end

    a_dbus_cyc_stb: assert property (@(posedge aclk) disable iff (rst)
        dbus_req.cyc == dbus_req.stb)
        else begin $error("dbus cyc and stb differ"); fails++; end

    // request held until the slave acks
    a_ibus_stable: assert property (@(posedge aclk) disable iff (rst)
        ibus_req.cyc && !ibus_rsp.ack |=> ibus_req.cyc && $stable(ibus_req.adr)
            && $stable(ibus_req.we) && $stable(ibus_req.dat_w) && $stable(ibus_req.sel))
        else begin $error("ibus request changed before ack"); fails++; end

    a_dbus_stable: assert property (@(posedge aclk) disable iff (rst)
        dbus_req.cyc && !dbus_rsp.ack |=> dbus_req.cyc && $stable(dbus_req.adr)
            && $stable(dbus_req.we) && $stable(dbus_req.dat_w) && $stable(dbus_req.sel))
        else begin $error("dbus request changed before ack"); fails++; end

    a_ibus_drop: assert property (@(posedge aclk) disable iff (rst)
        ibus_rsp.ack |=> !ibus_req.cyc && !ibus_req.stb)
        else begin $error("ibus cyc still high after ack"); fails++; end

    a_dbus_drop: assert property (@(posedge aclk) disable iff (rst)
        dbus_rsp.ack |=> !dbus_req.cyc && !dbus_req.stb)
        else begin $error("dbus cyc still high after ack"); fails++; end

    // state right after a reset edge
    a_reset_idle: assert property (@(posedge aclk)
        rst |=> !ibus_req.cyc && !dbus_req.cyc && debug_wb_rf_wen == 4'h0)
        else begin $error("bus or trace active out of reset"); fails++; end

    a_trace_r0: assert property (@(posedge aclk) disable iff (rst)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
        else begin $error("trace reports a write to r0"); fails++; end

endmodule

`default_nettype wire

//--- logic/mycpu_top.sv
// four stage mips core top
`timescale 1ns/1ps
`default_nettype none

module mycpu_top #(
    parameter cpu_defs_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic                aclk,
    input  logic                rst,
    output wb_bus_pkg::wb_req_t ibus_req,
    input  wb_bus_pkg::wb_rsp_t ibus_rsp,
    output wb_bus_pkg::wb_req_t dbus_req,
    input  wb_bus_pkg::wb_rsp_t dbus_rsp,
    output logic [31:0]         debug_wb_pc,
    output logic [31:0]         debug_wb_rf_wdata,
    output logic [3:0]          debug_wb_rf_wen,
    output logic [4:0]          debug_wb_rf_wnum
);
    logic                    if_hold, id_hold, ex_hold, if_flush, id_flush;
    logic                    ibus_busy, dbus_busy;
    logic                    branch_taken;
    cpu_defs_pkg::word_t     branch_target;
    logic                    if_valid;
    cpu_defs_pkg::word_t     if_pc, if_instr;
    cpu_defs_pkg::id_ex_t    id_ex;
    cpu_defs_pkg::wb_write_t ex_wb;
    cpu_defs_pkg::wb_write_t wb_q;  // writeback register

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .aclk          (aclk),
        .rst           (rst),
        .if_hold       (if_hold),
        .if_flush      (if_flush),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ibus_req      (ibus_req),
        .ibus_rsp      (ibus_rsp),
        .ibus_busy     (ibus_busy),
        .if_valid      (if_valid),
        .if_pc         (if_pc),
        .if_instr      (if_instr)
    );

    decode_stage u_decode (
        .aclk     (aclk),
        .rst      (rst),
        .id_hold  (id_hold),
        .id_flush (id_flush),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .wb_write (wb_q),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .aclk          (aclk),
        .rst           (rst),
        .ex_hold       (ex_hold),
        .id_ex         (id_ex),
        .wb_fwd        (wb_q),
        .dbus_req      (dbus_req),
        .dbus_rsp      (dbus_rsp),
        .dbus_busy     (dbus_busy),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_wb         (ex_wb)
    );

    pipeline_control u_control (
        .ibus_busy    (ibus_busy),
        .dbus_busy    (dbus_busy),
        .branch_taken (branch_taken),
        .if_hold      (if_hold),
        .id_hold      (id_hold),
        .ex_hold      (ex_hold),
        .if_flush     (if_flush),
        .id_flush     (id_flush)
    );

    always_ff @(posedge aclk) begin
        if (rst)
            wb_q.valid <= 1'b0;
        else
            wb_q <= ex_wb;
    end

    // golden trace, writes to r0 are not reported
    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wdata = wb_q.data;
    assign debug_wb_rf_wnum  = wb_q.dst;
    assign debug_wb_rf_wen   = (wb_q.valid && wb_q.wen && wb_q.dst != '0) ? 4'hf : 4'h0;

endmodule

`default_nettype wire

//--- logic/pipeline_control.sv
// pipeline stall and flush control
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  logic ibus_busy,
    input  logic dbus_busy,
    input  logic branch_taken,
    output logic if_hold,
    output logic id_hold,
    output logic ex_hold,
    output logic if_flush,
    output logic id_flush
);

    // a data bus wait stalls everything upstream of execute
    assign ex_hold = dbus_busy;
    assign id_hold = dbus_busy;

    // fetch output also stays put while the instruction bus waits
    assign if_hold = dbus_busy | ibus_busy;

    // branch only resolves with no lw/sw in execute,
    // so a redirect never meets a data stall
    assign if_flush = branch_taken;
    assign id_flush = branch_taken;

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
// execute stage with data bus master
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                    aclk,
    input  logic                    rst,
    input  logic                    ex_hold,
    input  cpu_defs_pkg::id_ex_t    id_ex,
    input  cpu_defs_pkg::wb_write_t wb_fwd,
    output wb_bus_pkg::wb_req_t     dbus_req,
    input  wb_bus_pkg::wb_rsp_t     dbus_rsp,
    output logic                    dbus_busy,
    output logic                    branch_taken,
    output cpu_defs_pkg::word_t     branch_target,
    output cpu_defs_pkg::wb_write_t ex_wb
);
    cpu_defs_pkg::word_t a_fwd, b_fwd, alu_b, alu_y, br_target;
    cpu_defs_pkg::word_t adr_q, dat_q;  // request kept while the lw/sw waits
    logic                held_q;        // same instruction as last cycle
    logic                recover_q;     // ack seen last cycle, cyc must stay low
    logic                mem_op, cyc, done;

    // writeback register bypass, r0 never forwarded
    function automatic cpu_defs_pkg::word_t fwd(input cpu_defs_pkg::reg_idx_t idx,
                                                input cpu_defs_pkg::word_t val);
        if (wb_fwd.valid && wb_fwd.wen && wb_fwd.dst != '0 && wb_fwd.dst == idx)
            return wb_fwd.data;
        else
            return val;
    endfunction

    assign a_fwd = fwd(id_ex.a_idx, id_ex.a_val);
    assign b_fwd = fwd(id_ex.b_idx, id_ex.b_val);
    assign alu_b = id_ex.imm_sel ? id_ex.imm : b_fwd;

    always_comb begin
        case (id_ex.alu_op)
            cpu_defs_pkg::alu_sub: alu_y = a_fwd - alu_b;
            cpu_defs_pkg::alu_and: alu_y = a_fwd & alu_b;
            cpu_defs_pkg::alu_or:  alu_y = a_fwd | alu_b;
            cpu_defs_pkg::alu_xor: alu_y = a_fwd ^ alu_b;
            cpu_defs_pkg::alu_slt: alu_y = {31'b0, $signed(a_fwd) < $signed(alu_b)};
            cpu_defs_pkg::alu_lui: alu_y = {alu_b[15:0], 16'h0000};
            default:               alu_y = a_fwd + alu_b;
        endcase
    end

    // branch and jump resolution
    assign br_target     = id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};
    assign branch_target = id_ex.jump ? id_ex.jump_target : br_target;
    assign branch_taken  = id_ex.valid & (id_ex.jump
                         | (id_ex.br_eq & (a_fwd == b_fwd))
                         | (id_ex.br_ne & (a_fwd != b_fwd)));

    // data bus cycle, first cycle drives the live values
    assign mem_op    = id_ex.valid & (id_ex.mem_read | id_ex.mem_write);
    assign cyc       = mem_op & !recover_q;
    assign done      = cyc & dbus_rsp.ack;
    assign dbus_busy = mem_op & !done;

    always_comb begin
        dbus_req.cyc   = cyc;
        dbus_req.stb   = cyc;
        dbus_req.we    = id_ex.mem_write;
        dbus_req.adr   = held_q ? adr_q : alu_y;
        dbus_req.dat_w = held_q ? dat_q : b_fwd;
        dbus_req.sel   = 4'hf;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            held_q    <= 1'b0;
            recover_q <= 1'b0;
        end else begin
            held_q    <= ex_hold;
            recover_q <= done;
        end
    end

    always_ff @(posedge aclk) begin
        if (!held_q) begin
            adr_q <= alu_y;
            dat_q <= b_fwd;
        end
    end

    // bubble to writeback while the bus waits
    always_comb begin
        ex_wb.valid = id_ex.valid & !dbus_busy;
        ex_wb.pc    = id_ex.pc;
        ex_wb.dst   = id_ex.dst;
        ex_wb.data  = id_ex.mem_read ? dbus_rsp.dat_r : alu_y;
        ex_wb.wen   = id_ex.reg_write;
    end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                    aclk,
    input  logic                    rst,
    input  logic                    id_hold,
    input  logic                    id_flush,
    input  logic                    if_valid,
    input  cpu_defs_pkg::word_t     if_pc,
    input  cpu_defs_pkg::word_t     if_instr,
    input  cpu_defs_pkg::wb_write_t wb_write,
    output cpu_defs_pkg::id_ex_t    id_ex
);
    cpu_defs_pkg::opcode_e  op;
    cpu_defs_pkg::funct_e   fn;
    cpu_defs_pkg::reg_idx_t rs, rt, rd;
    cpu_defs_pkg::word_t    ra_data, rb_data;
    cpu_defs_pkg::word_t    imm_s, imm_z, pc_plus4;
    cpu_defs_pkg::id_ex_t   dec;

    assign op       = cpu_defs_pkg::opcode_e'(if_instr[31:26]);
    assign fn       = cpu_defs_pkg::funct_e'(if_instr[5:0]);
    assign rs       = if_instr[25:21];
    assign rt       = if_instr[20:16];
    assign rd       = if_instr[15:11];
    assign imm_s    = {{16{if_instr[15]}}, if_instr[15:0]};
    assign imm_z    = {16'h0000, if_instr[15:0]};
    assign pc_plus4 = if_pc + 32'd4;

    reg_file u_reg_file (
        .aclk     (aclk),
        .rst      (rst),
        .ra_idx   (rs),
        .rb_idx   (rt),
        .ra_data  (ra_data),
        .rb_data  (rb_data),
        .wb_write (wb_write)
    );

    always_comb begin
        dec             = '0;
        dec.valid       = if_valid & !id_flush;
        dec.pc          = if_pc;
        dec.a_idx       = rs;
        dec.a_val       = ra_data;
        dec.b_idx       = rt;
        dec.b_val       = rb_data;
        dec.imm         = imm_s;
        dec.alu_op      = cpu_defs_pkg::alu_add;
        dec.dst         = rt;   // i-type default
        dec.jump_target = {pc_plus4[31:28], if_instr[25:0], 2'b00};
        case (op)
            cpu_defs_pkg::op_special: begin
                dec.dst       = rd;
                dec.reg_write = 1'b1;
                case (fn)
                    cpu_defs_pkg::fn_addu: dec.alu_op = cpu_defs_pkg::alu_add;
                    cpu_defs_pkg::fn_subu: dec.alu_op = cpu_defs_pkg::alu_sub;
                    cpu_defs_pkg::fn_and:  dec.alu_op = cpu_defs_pkg::alu_and;
                    cpu_defs_pkg::fn_or:   dec.alu_op = cpu_defs_pkg::alu_or;
                    cpu_defs_pkg::fn_xor:  dec.alu_op = cpu_defs_pkg::alu_xor;
                    cpu_defs_pkg::fn_slt:  dec.alu_op = cpu_defs_pkg::alu_slt;
                    default:               dec.reg_write = 1'b0;   // treated as nop
                endcase
            end
            cpu_defs_pkg::op_addiu: begin
                dec.imm_sel   = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_defs_pkg::op_ori: begin
                dec.imm_sel   = 1'b1;
                dec.imm       = imm_z;
                dec.alu_op    = cpu_defs_pkg::alu_or;
                dec.reg_write = 1'b1;
            end
            cpu_defs_pkg::op_lui: begin
                dec.imm_sel   = 1'b1;
                dec.imm       = imm_z;
                dec.alu_op    = cpu_defs_pkg::alu_lui;
                dec.reg_write = 1'b1;
            end
            cpu_defs_pkg::op_beq: dec.br_eq = 1'b1;
            cpu_defs_pkg::op_bne: dec.br_ne = 1'b1;
            cpu_defs_pkg::op_j:   dec.jump  = 1'b1;
            cpu_defs_pkg::op_lw: begin
                dec.imm_sel   = 1'b1;   // address = rs + offset
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_defs_pkg::op_sw: begin
                dec.imm_sel   = 1'b1;
                dec.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst)
            id_ex.valid <= 1'b0;
        else if (!id_hold)
            id_ex <= dec;
    end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter cpu_defs_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic                 aclk,
    input  logic                 rst,
    input  logic                 if_hold,
    input  logic                 if_flush,
    input  logic                 branch_taken,
    input  cpu_defs_pkg::word_t  branch_target,
    output wb_bus_pkg::wb_req_t  ibus_req,
    input  wb_bus_pkg::wb_rsp_t  ibus_rsp,
    output logic                 ibus_busy,
    output logic                 if_valid,
    output cpu_defs_pkg::word_t  if_pc,
    output cpu_defs_pkg::word_t  if_instr
);
    cpu_defs_pkg::fetch_state_e state;
    cpu_defs_pkg::word_t        pc;         // next fetch address
    cpu_defs_pkg::word_t        adr_q;      // address of the cycle on the bus
    logic                       discard;    // in-flight word is wrong path
    logic                       in_flight;
    logic                       got_word;
    logic                       start;

    assign in_flight = (state == cpu_defs_pkg::st_wait_ack);
    assign got_word  = in_flight & ibus_rsp.ack & !discard & !if_flush;
    assign ibus_busy = in_flight & !ibus_rsp.ack;

    // only start when the output buffer is free by the end of this cycle
    assign start = (state == cpu_defs_pkg::st_idle) & !branch_taken & (!if_valid | !if_hold);

    always_comb begin
        ibus_req.cyc   = in_flight;
        ibus_req.stb   = in_flight;
        ibus_req.we    = 1'b0;
        ibus_req.adr   = adr_q;
        ibus_req.dat_w = '0;
        ibus_req.sel   = 4'hf;  // word reads only
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= cpu_defs_pkg::st_idle;
            pc       <= reset_pc;
            discard  <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if (start) begin
                state <= cpu_defs_pkg::st_wait_ack;
                pc    <= pc + 32'd4;
            end else if (in_flight && ibus_rsp.ack) begin
                state <= cpu_defs_pkg::st_idle;     // cyc low for one cycle
            end
            if (branch_taken)
                pc <= branch_target;
            if (in_flight && ibus_rsp.ack)
                discard <= 1'b0;
            else if (in_flight && branch_taken)
                discard <= 1'b1;    // let the cycle finish, drop its word
            if (got_word)
                if_valid <= 1'b1;
            else if (if_flush || !if_hold)
                if_valid <= 1'b0;   // taken by decode or killed
        end
    end

    always_ff @(posedge aclk) begin
        if (start)
            adr_q <= pc;
        if (got_word) begin
            if_pc    <= adr_q;
            if_instr <= ibus_rsp.dat_r;
        end
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
// general purpose register file
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                    aclk,
    input  logic                    rst,
    input  cpu_defs_pkg::reg_idx_t  ra_idx,
    input  cpu_defs_pkg::reg_idx_t  rb_idx,
    output cpu_defs_pkg::word_t     ra_data,
    output cpu_defs_pkg::word_t     rb_data,
    input  cpu_defs_pkg::wb_write_t wb_write
);
    cpu_defs_pkg::word_t regs [32];
    logic                wr_hit;

    assign wr_hit = wb_write.valid & wb_write.wen & (wb_write.dst != '0);

    // r0 reads zero, same-cycle write passes straight through
    function automatic cpu_defs_pkg::word_t rd_port(input cpu_defs_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wr_hit && idx == wb_write.dst)
            return wb_write.data;
        else
            return regs[idx];
    endfunction

    assign ra_data = rd_port(ra_idx);
    assign rb_data = rd_port(rb_idx);

    always_ff @(posedge aclk) begin
        if (!rst && wr_hit)
            regs[wb_write.dst] <= wb_write.data;
    end

endmodule

`default_nettype wire

//--- logic/wb_bus_pkg.sv
// wishbone classic bus types
`default_nettype none

package wb_bus_pkg;

    // master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat_w;
        logic [3:0]  sel;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- logic/cpu_defs_pkg.sv
// cpu core definitions
`default_nettype none

package cpu_defs_pkg;

    parameter int data_w    = 32;
    parameter int reg_idx_w = 5;

    typedef logic [data_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_e;

    typedef enum logic {
        st_idle,
        st_wait_ack
    } fetch_state_e;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    a_val;
        reg_idx_t a_idx;
        word_t    b_val;
        reg_idx_t b_idx;
        logic     imm_sel;      // b operand from imm
        word_t    imm;
        alu_op_e  alu_op;
        reg_idx_t dst;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     br_eq;
        logic     br_ne;
        logic     jump;
        word_t    jump_target;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t dst;
        word_t    data;
        logic     wen;
    } wb_write_t;

endpackage

`default_nettype wire
